//--- tinyrv_dispatch.f
+incdir+include
logic/tinyrv_pkg.sv
logic/dx_intf.sv
logic/inst_decoder.sv
logic/inst_router.sv
logic/exec_pipe.sv
logic/tinyrv_dispatch_top.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_top
FILELIST  = tinyrv_dispatch.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation passes only if the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_top.sv
//----------------------------------------------------------------------
// TinyRV dispatch testbench
// Clock, reset, stimulus table with random gaps, checker and watchdog
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 24;
  // Worst case per row plus slack for reset and drain
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (`MUL_LATENCY + 8) + 40;

  logic                              clk;
  logic                              rst_n;
  logic [31:0]                       inst;
  logic [`TAG_W-1:0]                 inst_tag;
  logic                              inst_val;
  logic                              inst_rdy;
  logic [`NUM_PIPES-1:0]             cmpl_val;
  logic [`NUM_PIPES-1:0][`TAG_W-1:0] cmpl_tag;
  tinyrv_pkg::rv_uop                 cmpl_uop [`NUM_PIPES];
  logic                              illegal_val;
  logic [`TAG_W-1:0]                 illegal_tag;

  // Stimulus table, tag equals row index
  logic [31:0] row_word [NUM_ROWS];
  logic [2:0]  row_uop [NUM_ROWS];
  logic        row_illegal [NUM_ROWS];
  logic        row_nogap [NUM_ROWS];
  // Expected pipe, 3 for any capable one
  logic [1:0]  row_pipe [NUM_ROWS];

  int          err_cnt;
  int          ok_cnt;
  int          rows_done;
  logic [31:0] rng;
  logic [1:0]  gap;
  logic        taken;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  tinyrv_dispatch_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .inst_tag   (inst_tag),
    .inst_val   (inst_val),
    .inst_rdy   (inst_rdy),
    .cmpl_val   (cmpl_val),
    .cmpl_tag   (cmpl_tag),
    .cmpl_uop   (cmpl_uop),
    .illegal_val(illegal_val),
    .illegal_tag(illegal_tag)
  );

  tb_checker #(
    .NUM_ROWS(NUM_ROWS)
  ) chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_rdy   (inst_rdy),
    .cmpl_val   (cmpl_val),
    .cmpl_tag   (cmpl_tag),
    .cmpl_uop   (cmpl_uop),
    .illegal_val(illegal_val),
    .illegal_tag(illegal_tag),
    .exp_uop    (row_uop),
    .exp_illegal(row_illegal),
    .exp_pipe   (row_pipe),
    .err_cnt    (err_cnt),
    .ok_cnt     (ok_cnt),
    .rows_done  (rows_done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic put_row(input int r, input logic [31:0] word, input tinyrv_pkg::rv_uop uop,
                         input logic nogap, input logic [1:0] pipe);
    row_word[r]    = word;
    row_uop[r]     = 3'(uop);
    row_illegal[r] = 1'b0;
    row_nogap[r]   = nogap;
    row_pipe[r]    = pipe;
  endtask

  task automatic mark_illegal(input int r, input logic [31:0] word);
    row_word[r]    = word;
    row_uop[r]     = 3'd0;
    row_illegal[r] = 1'b1;
    row_nogap[r]   = 1'b0;
    row_pipe[r]    = 2'd3;
  endtask

  //--------------------------------------------------------------------
  // Rows: word, class, no gap before it, expected pipe
  //--------------------------------------------------------------------

  task automatic load_table();
    put_row(0, 32'h002081b3, tinyrv_pkg::OP_ADD, 1'b0, 2'd0);
    put_row(1, 32'h0000a283, tinyrv_pkg::OP_LW, 1'b0, 2'd2);
    // LW in between leaves pipe 0 idle
    put_row(2, 32'h002081b3, tinyrv_pkg::OP_ADD, 1'b0, 2'd0);
    put_row(3, 32'h0050a223, tinyrv_pkg::OP_SW, 1'b0, 2'd2);
    // ADDI, opcode outside the subset
    mark_illegal(4, 32'h00000013);
    put_row(5, 32'h00209463, tinyrv_pkg::OP_BNE, 1'b0, 2'd0);
    // SUB, unknown funct7
    mark_illegal(6, 32'h402081b3);
    put_row(7, 32'h0000a283, tinyrv_pkg::OP_LW, 1'b0, 2'd2);
    put_row(8, 32'h008000ef, tinyrv_pkg::OP_JAL, 1'b0, 2'd0);
    // Pipe 0 still holds the JAL
    put_row(9, 32'h002081b3, tinyrv_pkg::OP_ADD, 1'b1, 2'd1);
    put_row(10, 32'h00008067, tinyrv_pkg::OP_JALR, 1'b0, 2'd0);
    put_row(11, 32'h022081b3, tinyrv_pkg::OP_MUL, 1'b0, 2'd1);
    put_row(12, 32'h002081b3, tinyrv_pkg::OP_ADD, 1'b1, 2'd0);
    mark_illegal(13, 32'hffffffff);
    // MUL burst, back-pressures decode
    put_row(14, 32'h022081b3, tinyrv_pkg::OP_MUL, 1'b0, 2'd1);
    put_row(15, 32'h022081b3, tinyrv_pkg::OP_MUL, 1'b1, 2'd1);
    put_row(16, 32'h022081b3, tinyrv_pkg::OP_MUL, 1'b1, 2'd1);
    put_row(17, 32'h022081b3, tinyrv_pkg::OP_MUL, 1'b1, 2'd1);
    put_row(18, 32'h002081b3, tinyrv_pkg::OP_ADD, 1'b1, 2'd0);
    put_row(19, 32'h0050a223, tinyrv_pkg::OP_SW, 1'b0, 2'd2);
    mark_illegal(20, 32'h042081b3);
    put_row(21, 32'h00209463, tinyrv_pkg::OP_BNE, 1'b0, 2'd0);
    // Pipe 0 busy with the BNE
    put_row(22, 32'h002081b3, tinyrv_pkg::OP_ADD, 1'b1, 2'd1);
    put_row(23, 32'h0000a283, tinyrv_pkg::OP_LW, 1'b0, 2'd2);
  endtask

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------

  initial begin
    rst_n    = 1'b0;
    inst     = '0;
    inst_tag = '0;
    inst_val = 1'b0;
    rng      = 32'hf3dc;
    load_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      rng = xorshift32(rng);
      gap = row_nogap[r] ? 2'd0 : rng[1:0];
      if (gap != 2'd0) begin
        inst_val <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      inst     <= row_word[r];
      inst_tag <= `TAG_W'(r);
      inst_val <= 1'b1;
      // Hold until the decoder takes it
      do begin
        @(negedge clk);
        taken = inst_rdy;
        @(posedge clk);
      end while (!taken);
    end
    inst_val <= 1'b0;
    wait (rows_done == NUM_ROWS);
    // Room for a stray late completion
    repeat (`MUL_LATENCY + 4) @(posedge clk);
    $display("rows resolved %0d of %0d, clean %0d, errors %0d",
             rows_done, NUM_ROWS, ok_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("ERROR: timeout after %0d cycles, only %0d of %0d rows resolved",
             TIMEOUT_CYCLES, rows_done, NUM_ROWS);
    $display("test failed");
    $finish;
  end

endmodule

//--- tb/tb_checker.sv
//----------------------------------------------------------------------
// TinyRV dispatch result checker
// Watches completions and illegal reports and scores each row by its tag
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

module tb_checker #(
  parameter int NUM_ROWS = 24
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              inst_rdy,
  input  logic [`NUM_PIPES-1:0]             cmpl_val,
  input  logic [`NUM_PIPES-1:0][`TAG_W-1:0] cmpl_tag,
  input  tinyrv_pkg::rv_uop                 cmpl_uop [`NUM_PIPES],
  input  logic                              illegal_val,
  input  logic [`TAG_W-1:0]                 illegal_tag,
  input  logic [2:0]                        exp_uop [NUM_ROWS],
  input  logic                              exp_illegal [NUM_ROWS],
  input  logic [1:0]                        exp_pipe [NUM_ROWS],
  output int                                err_cnt,
  output int                                ok_cnt,
  output int                                rows_done
);
  timeunit 1ns;
  timeprecision 1ps;

  int   errs = 0;
  int   oks = 0;
  int   done_cnt = 0;
  // Times each row was resolved
  int   seen [NUM_ROWS] = '{default: 0};
  // Last tag completed per pipe
  int   last_tag [`NUM_PIPES] = '{default: -1};
  int   last_mul_cyc = -100;
  int   cyc = 0;
  logic reset_seen = 1'b0;

  assign err_cnt   = errs;
  assign ok_cnt    = oks;
  assign rows_done = done_cnt;

  // Capability mask of one pipe
  function automatic tinyrv_pkg::rv_op_vec pipe_mask(input int p);
    case (p)
      0:       return `PIPE0_OPS;
      1:       return `PIPE1_OPS;
      default: return `PIPE2_OPS;
    endcase
  endfunction

  //--------------------------------------------------------------------
  // Completion scoring
  //--------------------------------------------------------------------

  task automatic score_completion(input int p, input int t, input tinyrv_pkg::rv_uop uop);
    tinyrv_pkg::rv_op_vec  mask;
    logic [`NUM_PIPES-1:0] want_val;
    logic [`NUM_PIPES-1:0] got_val;
    int                    errs_before;
    errs_before = errs;
    if (t >= NUM_ROWS) begin
      $display("ERROR: pipe %0d completed tag 0x%0h, which no row issued", p, t);
      errs++;
      return;
    end
    if (exp_illegal[t]) begin
      $display("ERROR: row %0d is an illegal word but completed on pipe %0d", t, p);
      errs++;
      return;
    end
    if (seen[t] != 0) begin
      $display("ERROR: row %0d completed a second time, on pipe %0d", t, p);
      errs++;
      return;
    end
    // Decoded class
    if (3'(uop) != exp_uop[t]) begin
      $display("MISMATCH cmpl_uop[%0d] row %0d: expected 0x%h got 0x%h",
               p, t, exp_uop[t], 3'(uop));
      errs++;
    end
    // Pipe has to be able to run the op
    mask = pipe_mask(p);
    if (mask[3'(uop)] != 1'b1) begin
      $display("ERROR: row %0d completed on pipe %0d, which cannot run that op", t, p);
      errs++;
    end
    // First-ready choice unless the row allows any capable pipe
    if (exp_pipe[t] != 2'd3) begin
      want_val = `NUM_PIPES'(1) << exp_pipe[t];
      got_val  = `NUM_PIPES'(1) << p;
      if (want_val != got_val) begin
        $display("MISMATCH cmpl_val row %0d: expected 0x%h got 0x%h", t, want_val, got_val);
        errs++;
      end
    end
    // Acceptance order per pipe
    if (t <= last_tag[p]) begin
      $display("ERROR: pipe %0d completed row %0d after row %0d", p, t, last_tag[p]);
      errs++;
    end
    // A MUL enters only after the completion cycle of the one before it
    if (uop == tinyrv_pkg::OP_MUL) begin
      if (cyc - last_mul_cyc < `MUL_LATENCY + 1) begin
        $display("ERROR: MUL row %0d completed only %0d cycles after the previous MUL",
                 t, cyc - last_mul_cyc);
        errs++;
      end
      last_mul_cyc = cyc;
    end
    last_tag[p] = t;
    seen[t]++;
    done_cnt++;
    if (errs == errs_before) begin
      oks++;
      $display("row %0d: %s on pipe %0d ok", t, uop.name(), p);
    end else begin
      $display("row %0d: %s on pipe %0d FAILED", t, uop.name(), p);
    end
  endtask

  task automatic verify_illegal_report(input int t);
    if (t >= NUM_ROWS) begin
      $display("ERROR: illegal report with tag 0x%0h, which no row issued", t);
      errs++;
    end else if (!exp_illegal[t]) begin
      $display("ERROR: row %0d is a legal word but was reported illegal", t);
      errs++;
    end else if (seen[t] != 0) begin
      $display("ERROR: row %0d reported illegal a second time", t);
      errs++;
    end else begin
      seen[t]++;
      done_cnt++;
      oks++;
      $display("row %0d: illegal word reported ok", t);
    end
  endtask

  //--------------------------------------------------------------------
  // Sampled mid-cycle where outputs have settled
  //--------------------------------------------------------------------

  always @(negedge clk) begin
    if (rst_n) begin
      // First cycle out of reset
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (cmpl_val != '0 || illegal_val || !inst_rdy) begin
          $display("ERROR: outputs not at reset values after reset release");
          errs++;
        end
      end
      for (int p = 0; p < `NUM_PIPES; p++) begin
        if (cmpl_val[p]) begin
          score_completion(p, int'(cmpl_tag[p]), cmpl_uop[p]);
        end
      end
      if (illegal_val) begin
        verify_illegal_report(int'(illegal_tag));
      end
      cyc++;
    end
  end

endmodule

//--- logic/tinyrv_dispatch_top.sv
//----------------------------------------------------------------------
// TinyRV dispatch top level
// Decoder feeding the router, router feeding the execute pipes
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

module tinyrv_dispatch_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [31:0]                      inst,
  input  logic [`TAG_W-1:0]                inst_tag,
  input  logic                             inst_val,
  output logic                             inst_rdy,
  output logic [`NUM_PIPES-1:0]            cmpl_val,
  output logic [`NUM_PIPES-1:0][`TAG_W-1:0] cmpl_tag,
  output tinyrv_pkg::rv_uop                cmpl_uop [`NUM_PIPES],
  output logic                             illegal_val,
  output logic [`TAG_W-1:0]                illegal_tag
);

  // Decode to router
  dx_intf dec_dx ();
  // Router to pipes
  dx_intf pipe_dx [`NUM_PIPES] ();

  inst_decoder decoder_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .inst_tag   (inst_tag),
    .inst_val   (inst_val),
    .inst_rdy   (inst_rdy),
    .illegal_val(illegal_val),
    .illegal_tag(illegal_tag),
    .dx         (dec_dx)
  );

  inst_router router_i (
    .dx(dec_dx),
    .ex(pipe_dx)
  );

  for (genvar i = 0; i < `NUM_PIPES; i++) begin : g_pipe
    exec_pipe pipe_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .dx      (pipe_dx[i]),
      .cmpl_val(cmpl_val[i]),
      .cmpl_tag(cmpl_tag[i]),
      .cmpl_uop(cmpl_uop[i])
    );
  end

endmodule

//--- logic/exec_pipe.sv
//----------------------------------------------------------------------
// Execute pipe occupancy model
// Holds one micro-op for an op-dependent latency, then pulses completion
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

module exec_pipe (
  input  logic              clk,
  input  logic              rst_n,
  dx_intf.x_intf            dx,
  output logic              cmpl_val,
  output logic [`TAG_W-1:0] cmpl_tag,
  output tinyrv_pkg::rv_uop cmpl_uop
);

  localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

  // Cycles left until completion, zero when idle
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] lat;
  logic             accept;

  // MUL holds the pipe longer
  assign lat = (dx.uop == tinyrv_pkg::OP_MUL) ? CNT_W'(`MUL_LATENCY) : CNT_W'(1);

  // Ready again in the completion cycle
  assign dx.rdy = (cnt == '0);
  assign accept = dx.val & dx.rdy;

  //--------------------------------------------------------------------
  // Busy counter and completion pulse
  //--------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      cmpl_val <= 1'b0;
    end else begin
      if (accept) begin
        cnt <= lat;
      end else if (cnt != '0) begin
        cnt <= cnt - CNT_W'(1);
      end
      // Last busy cycle leads into the pulse
      cmpl_val <= (cnt == CNT_W'(1));
    end
  end

  // Tag and uop held through the completion cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      cmpl_tag <= dx.tag;
      cmpl_uop <= dx.uop;
    end
  end

endmodule

//--- logic/inst_router.sv
//----------------------------------------------------------------------
// Instruction router
// Chain of per-pipe units, sends the micro-op to the lowest ready pipe
// that can run it; purely combinational
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

//----------------------------------------------------------------------
// One unit per pipe
//----------------------------------------------------------------------

module inst_router_unit #(
  parameter tinyrv_pkg::rv_op_vec op_subset = 7'b1111111
) (
  input  tinyrv_pkg::rv_uop uop,
  input  logic              uop_val,
  input  logic              already_found,
  input  logic              rdy,
  output logic              val,
  output logic              been_found
);

  logic can_run;

  // Capability test against the mask
  always_comb begin
    can_run = 1'b0;
    for (int k = 0; k < $bits(tinyrv_pkg::rv_op_vec); k++) begin
      if (op_subset[k] && uop == tinyrv_pkg::rv_uop'(k)) begin
        can_run = 1'b1;
      end
    end
  end

  // Offer only when no earlier pipe has claimed it
  assign val        = can_run & uop_val & ~already_found;
  // Claimed once a capable pipe is ready
  assign been_found = (can_run & rdy) | already_found;

endmodule

//----------------------------------------------------------------------
// Router
//----------------------------------------------------------------------

module inst_router (
  dx_intf.x_intf dx,
  dx_intf.d_intf ex [`NUM_PIPES]
);

  localparam tinyrv_pkg::rv_op_vec PIPE_OPS [`NUM_PIPES] = '{
    `PIPE0_OPS, `PIPE1_OPS, `PIPE2_OPS
  };

  // Claim chain, entry 0 is the head
  logic [`NUM_PIPES:0] found;

  assign found[0] = 1'b0;

  for (genvar i = 0; i < `NUM_PIPES; i++) begin : g_unit
    inst_router_unit #(
      .op_subset(PIPE_OPS[i])
    ) unit_i (
      .uop          (dx.uop),
      .uop_val      (dx.val),
      .already_found(found[i]),
      .rdy          (ex[i].rdy),
      .val          (ex[i].val),
      .been_found   (found[i+1])
    );

    // Payload fans out to every pipe
    assign ex[i].uop = dx.uop;
    assign ex[i].tag = dx.tag;
  end

  // End of chain set means the lowest offered pipe is ready
  assign dx.rdy = dx.val & found[`NUM_PIPES];

endmodule

//--- logic/inst_decoder.sv
//----------------------------------------------------------------------
// Instruction decoder
// Maps RV32 words onto TinyRV1 micro-ops, one-entry stage register,
// reports and drops illegal words
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

module inst_decoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [31:0]       inst,
  input  logic [`TAG_W-1:0] inst_tag,
  input  logic              inst_val,
  output logic              inst_rdy,
  output logic              illegal_val,
  output logic [`TAG_W-1:0] illegal_tag,
  dx_intf.d_intf            dx
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Decode result
  tinyrv_pkg::rv_uop dec_uop;
  logic              dec_illegal;

  // Stage register
  logic              stg_val;
  tinyrv_pkg::rv_uop stg_uop;
  logic [`TAG_W-1:0] stg_tag;

  logic accept;
  logic leave;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  //--------------------------------------------------------------------
  // Field match
  //--------------------------------------------------------------------

  always_comb begin
    dec_uop     = tinyrv_pkg::OP_ADD;
    dec_illegal = 1'b0;
    case (tinyrv_pkg::rv_opcode'(opcode))
      tinyrv_pkg::OPC_OP: begin
        // ADD and MUL share funct3, funct7 tells them apart
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          dec_uop = tinyrv_pkg::OP_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
          dec_uop = tinyrv_pkg::OP_MUL;
        end else begin
          dec_illegal = 1'b1;
        end
      end
      tinyrv_pkg::OPC_LOAD: begin
        dec_uop     = tinyrv_pkg::OP_LW;
        dec_illegal = (funct3 != 3'b010);
      end
      tinyrv_pkg::OPC_STORE: begin
        dec_uop     = tinyrv_pkg::OP_SW;
        dec_illegal = (funct3 != 3'b010);
      end
      tinyrv_pkg::OPC_JAL: begin
        dec_uop = tinyrv_pkg::OP_JAL;
      end
      tinyrv_pkg::OPC_JALR: begin
        dec_uop     = tinyrv_pkg::OP_JALR;
        dec_illegal = (funct3 != 3'b000);
      end
      tinyrv_pkg::OPC_BRANCH: begin
        // Only BNE in this subset
        dec_uop     = tinyrv_pkg::OP_BNE;
        dec_illegal = (funct3 != 3'b001);
      end
      default: begin
        dec_illegal = 1'b1;
      end
    endcase
  end

  //--------------------------------------------------------------------
  // Stage register and handshake
  //--------------------------------------------------------------------

  // Entry leaves when the router finds a ready pipe
  assign leave    = stg_val & dx.rdy;
  // Open when empty or draining this cycle
  assign inst_rdy = ~stg_val | leave;
  assign accept   = inst_val & inst_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_val     <= 1'b0;
      illegal_val <= 1'b0;
    end else begin
      // Illegal words never occupy the stage
      if (accept) begin
        stg_val <= ~dec_illegal;
      end else if (leave) begin
        stg_val <= 1'b0;
      end
      // One-cycle report per illegal word
      illegal_val <= accept & dec_illegal;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (accept && !dec_illegal) begin
      stg_uop <= dec_uop;
      stg_tag <= inst_tag;
    end
    if (accept && dec_illegal) begin
      illegal_tag <= inst_tag;
    end
  end

  assign dx.val = stg_val;
  assign dx.uop = stg_uop;
  assign dx.tag = stg_tag;

endmodule

//--- logic/dx_intf.sv
//----------------------------------------------------------------------
// Decode-to-execute link
// One micro-op with its sequence tag over a val/rdy handshake
//----------------------------------------------------------------------

`include "tinyrv_defs_defs.svh"

interface dx_intf;

  // Sender side
  logic              val;
  tinyrv_pkg::rv_uop uop;
  logic [`TAG_W-1:0] tag;

  // Receiver side
  logic              rdy;

  // Transfer on a rising edge with val and rdy both high
  modport d_intf (output val, output uop, output tag, input rdy);

  modport x_intf (input val, input uop, input tag, output rdy);

endinterface

//--- logic/tinyrv_pkg.sv
//----------------------------------------------------------------------
// TinyRV dispatch types
// Micro-op and major opcode encodings, op capability mask type
//----------------------------------------------------------------------

package tinyrv_pkg;

  // Micro-ops of the TinyRV1 subset
  // Encoding doubles as the bit index into rv_op_vec
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_MUL  = 3'd1,
    OP_LW   = 3'd2,
    OP_SW   = 3'd3,
    OP_JAL  = 3'd4,
    OP_JALR = 3'd5,
    OP_BNE  = 3'd6
  } rv_uop;

  // One bit per micro-op
  typedef logic [6:0] rv_op_vec;

  // RV32 major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } rv_opcode;

endpackage

//--- include/tinyrv_defs_defs.svh
//----------------------------------------------------------------------
// TinyRV dispatch parameters
// Pipe count, per-pipe op capability masks, tag width and MUL latency
//----------------------------------------------------------------------

`ifndef TINYRV_DEFS_DEFS_SVH
`define TINYRV_DEFS_DEFS_SVH

// Number of execute pipes behind the router
`define NUM_PIPES 3

// Capability masks, bit index is the rv_uop value
// Bit order: BNE JALR JAL SW LW MUL ADD
// Pipe 0 handles ADD, JAL, JALR, BNE
`define PIPE0_OPS 7'b1110001
// Pipe 1 handles ADD and MUL
`define PIPE1_OPS 7'b0000011
// Pipe 2 handles LW and SW
`define PIPE2_OPS 7'b0001100

// Sequence tag width
`define TAG_W 8

// Cycles a MUL keeps its pipe busy; all other ops take one
`define MUL_LATENCY 3

`endif
